/* vdp_pkg.sv */
`default_nettype none

package vdp_pkg;

    typedef logic [13:0] vram_addr_t;   // 16 KiB byte address
    typedef logic [7:0]  byte_t;
    typedef logic [3:0]  color_t;       // TI99 color index

    // video register numbers, as on the TMS9918
    typedef enum logic [2:0] {
        REG_MODE         = 3'd1,        // bit 6 enables the display
        REG_NAME_BASE    = 3'd2,        // 1 KiB units
        REG_COLOR_BASE   = 3'd3,        // 64 byte units
        REG_PATTERN_BASE = 3'd4,        // 2 KiB units
        REG_BACKDROP     = 3'd7         // low nibble
    } reg_index_e;

    typedef struct packed {
        logic       display_en;
        logic [3:0] name_base;
        byte_t      color_base;
        logic [2:0] pattern_base;
        color_t     backdrop;
    } vdp_regs_t;

    typedef struct packed {
        logic [8:0] x;
        logic [8:0] y;
        logic       de;
        logic       hsync;
        logic       vsync;
    } beam_t;

    typedef struct packed {
        color_t color;
        logic   de;
        logic   hsync;
        logic   vsync;
    } pixel_t;

    typedef enum logic [1:0] {
        FETCH_NAME,
        FETCH_PATTERN,
        FETCH_COLOR,
        FETCH_WAIT
    } fetch_phase_e;

    typedef enum logic {
        WB_IDLE,
        WB_ACK
    } wb_state_e;

    // graphics I screen geometry
    localparam int H_ACTIVE      = 256;
    localparam int V_ACTIVE      = 192;
    localparam int TILE          = 8;
    localparam int TILES_PER_ROW = 32;

endpackage

`default_nettype wire

/* vdp_host_port.sv */
`timescale 1ns/1ps
`default_nettype none

// wishbone classic slave for the CPU side
// adr[14] clear is VRAM, set is a video register

module vdp_host_port (
    input  logic                clk,
    input  logic                rst,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  logic [14:0]         wb_adr,
    input  vdp_pkg::byte_t      wb_dat_w,
    output vdp_pkg::byte_t      wb_dat_r,
    output logic                wb_ack,
    output vdp_pkg::vram_addr_t vram_addr,
    output logic                vram_we,
    output vdp_pkg::byte_t      vram_wdata,
    input  vdp_pkg::byte_t      vram_rdata,
    output vdp_pkg::vdp_regs_t  regs
);

    vdp_pkg::wb_state_e  state;
    vdp_pkg::reg_index_e reg_idx;
    vdp_pkg::byte_t      reg_rdata;
    logic                req;       // cycle accepted on this clock
    logic                reg_sel;

    assign req     = wb_cyc && wb_stb && (state == vdp_pkg::WB_IDLE);
    assign reg_sel = wb_adr[14];
    assign reg_idx = vdp_pkg::reg_index_e'(wb_adr[2:0]);

    // VRAM port A follows the bus directly
    assign vram_addr  = wb_adr[13:0];
    assign vram_we    = req && wb_we && !reg_sel;     // write lands on the accept edge
    assign vram_wdata = wb_dat_w;

    // ********************
    // handshake
    // ********************
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= vdp_pkg::WB_IDLE;
        end else if (req) begin
            state <= vdp_pkg::WB_ACK;
        end else begin
            state <= vdp_pkg::WB_IDLE;              // one ack cycle, then back
        end
    end

    assign wb_ack = (state == vdp_pkg::WB_ACK);

    // register file
    always_ff @(posedge clk) begin
        if (rst) begin
            regs <= '0;
        end else if (req && wb_we && reg_sel) begin
            case (reg_idx)
                vdp_pkg::REG_MODE:         regs.display_en   <= wb_dat_w[6];
                vdp_pkg::REG_NAME_BASE:    regs.name_base    <= wb_dat_w[3:0];
                vdp_pkg::REG_COLOR_BASE:   regs.color_base   <= wb_dat_w;
                vdp_pkg::REG_PATTERN_BASE: regs.pattern_base <= wb_dat_w[2:0];
                vdp_pkg::REG_BACKDROP:     regs.backdrop     <= wb_dat_w[3:0];
                default: ;                          // unused numbers
            endcase
        end
    end

    // read back only the implemented bits
    always_comb begin
        case (reg_idx)
            vdp_pkg::REG_MODE:         reg_rdata = {1'b0, regs.display_en, 6'b0};
            vdp_pkg::REG_NAME_BASE:    reg_rdata = {4'b0, regs.name_base};
            vdp_pkg::REG_COLOR_BASE:   reg_rdata = regs.color_base;
            vdp_pkg::REG_PATTERN_BASE: reg_rdata = {5'b0, regs.pattern_base};
            vdp_pkg::REG_BACKDROP:     reg_rdata = {4'b0, regs.backdrop};
            default:                   reg_rdata = '0;
        endcase
    end

    // address is held through ack, so the mux is stable then
    assign wb_dat_r = reg_sel ? reg_rdata : vram_rdata;

endmodule

`default_nettype wire

/* vdp_vram.sv */
`timescale 1ns/1ps
`default_nettype none

// 16 KiB video memory
// port A is the host, port B feeds the tile fetch

module vdp_vram (
    input  logic                clk,
    input  vdp_pkg::vram_addr_t a_addr,
    input  logic                a_we,
    input  vdp_pkg::byte_t      a_wdata,
    output vdp_pkg::byte_t      a_rdata,
    input  vdp_pkg::vram_addr_t b_addr,
    output vdp_pkg::byte_t      b_rdata
);

    localparam int DEPTH = 1 << $bits(vdp_pkg::vram_addr_t);

    vdp_pkg::byte_t mem [0:DEPTH-1];

    // host side, read before write
    always_ff @(posedge clk) begin
        if (a_we) begin
            mem[a_addr] <= a_wdata;
        end
        a_rdata <= mem[a_addr];
    end

    // video side is read only
    always_ff @(posedge clk) begin
        b_rdata <= mem[b_addr];
    end

endmodule

`default_nettype wire

/* vdp_timing.sv */
`timescale 1ns/1ps
`default_nettype none

// raster counters and sync windows

module vdp_timing #(
    parameter int H_TOTAL     = 342,
    parameter int V_TOTAL     = 262,
    parameter int HSYNC_START = 280,
    parameter int HSYNC_LEN   = 26,
    parameter int VSYNC_START = 216,
    parameter int VSYNC_LEN   = 3
) (
    input  logic           clk,
    input  logic           rst,
    output vdp_pkg::beam_t beam
);

    localparam logic [8:0] X_LAST   = 9'(H_TOTAL - 1);
    localparam logic [8:0] Y_LAST   = 9'(V_TOTAL - 1);
    localparam logic [8:0] X_ACTIVE = 9'(vdp_pkg::H_ACTIVE);
    localparam logic [8:0] Y_ACTIVE = 9'(vdp_pkg::V_ACTIVE);
    localparam logic [8:0] HS_BEGIN = 9'(HSYNC_START);
    localparam logic [8:0] HS_END   = 9'(HSYNC_START + HSYNC_LEN);
    localparam logic [8:0] VS_BEGIN = 9'(VSYNC_START);
    localparam logic [8:0] VS_END   = 9'(VSYNC_START + VSYNC_LEN);

    logic [8:0] x_next;
    logic [8:0] y_next;

    always_comb begin
        x_next = beam.x + 9'd1;
        y_next = beam.y;
        if (beam.x == X_LAST) begin
            x_next = '0;
            y_next = (beam.y == Y_LAST) ? 9'd0 : beam.y + 9'd1;   // frame wrap
        end
    end

    // flags come from the next position so all beam fields line up
    always_ff @(posedge clk) begin
        if (rst) begin
            beam.x     <= X_LAST;       // park on last dot, outside every window
            beam.y     <= Y_LAST;
            beam.de    <= 1'b0;
            beam.hsync <= 1'b0;
            beam.vsync <= 1'b0;
        end else begin
            beam.x     <= x_next;
            beam.y     <= y_next;
            beam.de    <= (x_next < X_ACTIVE) && (y_next < Y_ACTIVE);
            beam.hsync <= (x_next >= HS_BEGIN) && (x_next < HS_END);
            beam.vsync <= (y_next >= VS_BEGIN) && (y_next < VS_END);  // whole lines
        end
    end

endmodule

`default_nettype wire

/* tile_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

// graphics I tile engine
// fetches one tile ahead of the beam, then shifts it out

module tile_fetch #(
    parameter int H_TOTAL = 342
) (
    input  logic                clk,
    input  logic                rst,
    input  vdp_pkg::vdp_regs_t  regs,
    input  vdp_pkg::beam_t      beam,
    output vdp_pkg::vram_addr_t vram_addr,
    input  vdp_pkg::byte_t      vram_rdata,
    output vdp_pkg::pixel_t     pixel
);

    localparam logic [8:0] FETCH_START = 9'(H_TOTAL - vdp_pkg::TILE);   // col 0 window
    localparam logic [8:0] FETCH_END   = 9'((vdp_pkg::TILES_PER_ROW - 1) * vdp_pkg::TILE);
    localparam logic [8:0] X_ACTIVE    = 9'(vdp_pkg::H_ACTIVE);
    localparam logic [8:0] Y_ACTIVE    = 9'(vdp_pkg::V_ACTIVE);

    logic                  fetch_on;
    logic [2:0]            step;        // cycle within the 8 cycle window
    logic [4:0]            la_col;      // look-ahead tile column
    logic [8:0]            la_line;     // line the fetched tile belongs to
    vdp_pkg::fetch_phase_e phase;

    vdp_pkg::byte_t  name_q;
    vdp_pkg::byte_t  pat_next;
    vdp_pkg::byte_t  col_next;
    vdp_pkg::byte_t  shift_q;
    vdp_pkg::color_t fg_q;
    vdp_pkg::color_t bg_q;
    vdp_pkg::color_t chosen;
    logic            de_d;
    logic            hsync_d;
    logic            vsync_d;

    // ********************
    // fetch sequencer
    // ********************
    always_comb begin
        if (beam.x >= FETCH_START) begin
            fetch_on = 1'b1;                    // tail of line, first tile of next
            step     = 3'(beam.x - FETCH_START);
            la_col   = '0;
            la_line  = (beam.y >= Y_ACTIVE) ? 9'd0 : beam.y + 9'd1;
        end else begin
            fetch_on = beam.x < FETCH_END;
            step     = beam.x[2:0];
            la_col   = beam.x[7:3] + 5'd1;
            la_line  = beam.y;
        end
    end

    assign phase = vdp_pkg::fetch_phase_e'(step[2:1]);   // even step issues, odd latches

    always_comb begin
        case (phase)
            vdp_pkg::FETCH_PATTERN: vram_addr = {regs.pattern_base, name_q, la_line[2:0]};
            vdp_pkg::FETCH_COLOR:   vram_addr = {regs.color_base, 1'b0, name_q[7:3]};
            default:                vram_addr = {regs.name_base, la_line[7:3], la_col};
        endcase
    end

    // read data shows up the cycle after the address
    always_ff @(posedge clk) begin
        if (fetch_on && step[0]) begin
            case (phase)
                vdp_pkg::FETCH_NAME:    name_q   <= vram_rdata;
                vdp_pkg::FETCH_PATTERN: pat_next <= vram_rdata;
                vdp_pkg::FETCH_COLOR:   col_next <= vram_rdata;
                default: ;
            endcase
        end
    end

    // ********************
    // pixel shifter
    // ********************
    always_ff @(posedge clk) begin
        if ((beam.x[2:0] == 3'd0) && (beam.x < X_ACTIVE)) begin
            shift_q <= pat_next;                // tile boundary
            fg_q    <= col_next[7:4];
            bg_q    <= col_next[3:0];
        end else begin
            shift_q <= {shift_q[6:0], 1'b0};    // msb is leftmost pixel
        end
    end

    assign chosen = shift_q[7] ? fg_q : bg_q;

    // two stage output, flags ride alongside
    always_ff @(posedge clk) begin
        if (rst) begin
            de_d    <= 1'b0;
            hsync_d <= 1'b0;
            vsync_d <= 1'b0;
            pixel   <= '0;
        end else begin
            de_d        <= beam.de;
            hsync_d     <= beam.hsync;
            vsync_d     <= beam.vsync;
            pixel.de    <= de_d;
            pixel.hsync <= hsync_d;
            pixel.vsync <= vsync_d;
            if (!de_d) begin
                pixel.color <= '0;              // blanking
            end else if (!regs.display_en || (chosen == 4'h0)) begin
                pixel.color <= regs.backdrop;   // transparent shows backdrop
            end else begin
                pixel.color <= chosen;
            end
        end
    end

endmodule

`default_nettype wire

/* color_palette.sv */
`timescale 1ns/1ps
`default_nettype none

// TI99 color index to 2-2-2 levels for the video DAC

module color_palette (
    input  vdp_pkg::color_t color,
    output logic [1:0]      red,
    output logic [1:0]      grn,
    output logic [1:0]      blu
);

    // levels packed as {red, grn, blu}
    always_comb begin
        case (color)
            4'h0: {red, grn, blu} = 6'b00_00_00;    // transparent, black here
            4'h1: {red, grn, blu} = 6'b00_00_00;    // black
            4'h2: {red, grn, blu} = 6'b00_10_00;    // medium green
            4'h3: {red, grn, blu} = 6'b00_11_00;    // light green
            4'h4: {red, grn, blu} = 6'b00_00_01;    // dark blue
            4'h5: {red, grn, blu} = 6'b00_00_11;    // light blue
            4'h6: {red, grn, blu} = 6'b01_00_00;    // dark red
            4'h7: {red, grn, blu} = 6'b00_11_11;    // cyan
            4'h8: {red, grn, blu} = 6'b10_00_00;    // medium red
            4'h9: {red, grn, blu} = 6'b11_00_00;    // light red
            4'ha: {red, grn, blu} = 6'b01_01_00;    // dark yellow
            4'hb: {red, grn, blu} = 6'b11_11_00;    // light yellow
            4'hc: {red, grn, blu} = 6'b00_01_00;    // dark green
            4'hd: {red, grn, blu} = 6'b11_00_11;    // magenta
            4'he: {red, grn, blu} = 6'b01_01_01;    // gray
            4'hf: {red, grn, blu} = 6'b11_11_11;    // white
            default: {red, grn, blu} = 6'b00_00_00;
        endcase
    end

endmodule

`default_nettype wire

/* vdp_top.sv */
`timescale 1ns/1ps
`default_nettype none

// video display processor, graphics I only

module vdp_top #(
    parameter int H_TOTAL     = 342,
    parameter int V_TOTAL     = 262,
    parameter int HSYNC_START = 280,
    parameter int HSYNC_LEN   = 26,
    parameter int VSYNC_START = 216,
    parameter int VSYNC_LEN   = 3
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           wb_cyc,
    input  logic           wb_stb,
    input  logic           wb_we,
    input  logic [14:0]    wb_adr,
    input  vdp_pkg::byte_t wb_dat_w,
    output vdp_pkg::byte_t wb_dat_r,
    output logic           wb_ack,
    output logic [1:0]     red,
    output logic [1:0]     grn,
    output logic [1:0]     blu,
    output logic           de,
    output logic           hsync,
    output logic           vsync
);

    vdp_pkg::vram_addr_t host_addr;
    logic                host_we;
    vdp_pkg::byte_t      host_wdata;
    vdp_pkg::byte_t      host_rdata;
    vdp_pkg::vdp_regs_t  regs;
    vdp_pkg::beam_t      beam;
    vdp_pkg::vram_addr_t video_addr;
    vdp_pkg::byte_t      video_rdata;
    vdp_pkg::pixel_t     pixel;

    vdp_host_port host_i (
        .clk        (clk),
        .rst        (rst),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .vram_addr  (host_addr),
        .vram_we    (host_we),
        .vram_wdata (host_wdata),
        .vram_rdata (host_rdata),
        .regs       (regs)
    );

    vdp_vram vram_i (
        .clk     (clk),
        .a_addr  (host_addr),
        .a_we    (host_we),
        .a_wdata (host_wdata),
        .a_rdata (host_rdata),
        .b_addr  (video_addr),
        .b_rdata (video_rdata)
    );

    vdp_timing #(
        .H_TOTAL     (H_TOTAL),
        .V_TOTAL     (V_TOTAL),
        .HSYNC_START (HSYNC_START),
        .HSYNC_LEN   (HSYNC_LEN),
        .VSYNC_START (VSYNC_START),
        .VSYNC_LEN   (VSYNC_LEN)
    ) timing_i (
        .clk  (clk),
        .rst  (rst),
        .beam (beam)
    );

    tile_fetch #(
        .H_TOTAL (H_TOTAL)          // needs the line length for look-ahead
    ) fetch_i (
        .clk        (clk),
        .rst        (rst),
        .regs       (regs),
        .beam       (beam),
        .vram_addr  (video_addr),
        .vram_rdata (video_rdata),
        .pixel      (pixel)
    );

    color_palette palette_i (
        .color (pixel.color),
        .red   (red),
        .grn   (grn),
        .blu   (blu)
    );

    // flags already registered in the fetch pipe
    assign de    = pixel.de;
    assign hsync = pixel.hsync;
    assign vsync = pixel.vsync;

endmodule

`default_nettype wire

/* tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // reset spans the first rising edges, drops on a falling edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

/* vdp_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module vdp_chk (
    input logic clk,
    input logic rst,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic de,
    input logic hsync,
    input logic vsync
);

    int failures = 0;   // failed assertions so far

    // ack is a one cycle pulse
    ack_pulse: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
        else begin
            failures = failures + 1;
            $error("wb_ack stayed high for a second cycle");
        end

    // no ack without a cycle in progress
    ack_in_cycle: assert property (@(posedge clk) disable iff (rst) wb_ack |-> (wb_cyc && wb_stb))
        else begin
            failures = failures + 1;
            $error("wb_ack high while cyc or stb is low");
        end

    de_outside_sync: assert property (@(posedge clk) disable iff (rst)
        !(de && (hsync || vsync)))      // active video never overlaps sync
        else begin
            failures = failures + 1;
            $error("de high during hsync or vsync");
        end

endmodule

bind vdp_top vdp_chk chk_i (
    .clk    (clk),
    .rst    (rst),
    .wb_cyc (wb_cyc),
    .wb_stb (wb_stb),
    .wb_ack (wb_ack),
    .de     (de),
    .hsync  (hsync),
    .vsync  (vsync)
);

`default_nettype wire

/* vdp_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module vdp_tb;

    localparam int H_TOTAL        = 342;
    localparam int V_TOTAL        = 262;
    localparam int TIMEOUT_CYCLES = 7 * H_TOTAL * V_TOTAL + 2000;
    localparam int ACK_LIMIT      = 16;
    localparam int NAME_BYTES     = vdp_pkg::TILES_PER_ROW * vdp_pkg::V_ACTIVE / vdp_pkg::TILE;
    localparam int PAT_BYTES      = 2048;

    // set A and set B share one color table
    localparam int NAME_A    = 0;       // 1 KiB units
    localparam int PATTERN_A = 1;       // 2 KiB units
    localparam int NAME_B    = 4;
    localparam int PATTERN_B = 3;
    localparam int COLOR_AT  = 12;      // 0x0300 in 64 byte units

    logic           clk;
    logic           rst;
    logic           wb_cyc;
    logic           wb_stb;
    logic           wb_we;
    logic [14:0]    wb_adr;
    vdp_pkg::byte_t wb_dat_w;
    vdp_pkg::byte_t wb_dat_r;
    logic           wb_ack;
    logic [1:0]     red;
    logic [1:0]     grn;
    logic [1:0]     blu;
    logic           de;
    logic           hsync;
    logic           vsync;

    vdp_pkg::byte_t     vram_model [0:16383];   // mirror of host writes
    vdp_pkg::vdp_regs_t reg_model;
    int                 seed = 32'h81bd;
    int                 mismatches = 0;
    int                 other_errors = 0;
    int                 cycle_count = 0;

    tb_clock clock_i (
        .clk (clk),
        .rst (rst)
    );

    vdp_top #(
        .H_TOTAL (H_TOTAL),
        .V_TOTAL (V_TOTAL)
    ) vdp_top_i (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .red      (red),
        .grn      (grn),
        .blu      (blu),
        .de       (de),
        .hsync    (hsync),
        .vsync    (vsync)
    );

    // ********************
    // reference model
    // ********************
    function automatic logic [5:0] palette_rgb(vdp_pkg::color_t c);
        case (c)                                // {red, grn, blu}
            4'h2:    return 6'b00_10_00;
            4'h3:    return 6'b00_11_00;
            4'h4:    return 6'b00_00_01;        // dark blue
            4'h5:    return 6'b00_00_11;
            4'h6:    return 6'b01_00_00;
            4'h7:    return 6'b00_11_11;        // cyan
            4'h8:    return 6'b10_00_00;
            4'h9:    return 6'b11_00_00;        // light red
            4'ha:    return 6'b01_01_00;
            4'hb:    return 6'b11_11_00;
            4'hc:    return 6'b00_01_00;
            4'hd:    return 6'b11_00_11;
            4'he:    return 6'b01_01_01;
            4'hf:    return 6'b11_11_11;
            default: return 6'b00_00_00;        // 0 and 1 are black
        endcase
    endfunction

    function automatic vdp_pkg::color_t expected_color(int x, int y);
        vdp_pkg::vram_addr_t a;
        vdp_pkg::byte_t      n;
        vdp_pkg::byte_t      p;
        vdp_pkg::byte_t      c;
        logic [2:0]          bit_sel;
        vdp_pkg::color_t     pick;
        a = 14'(int'(reg_model.name_base) * 1024 + (y / 8) * 32 + x / 8);
        n = vram_model[a];
        a = 14'(int'(reg_model.pattern_base) * 2048 + int'(n) * 8 + y % 8);
        p = vram_model[a];
        a = 14'(int'(reg_model.color_base) * 64 + int'(n) / 8);
        c = vram_model[a];
        bit_sel = 3'(7 - x % 8);                // msb is the leftmost dot
        pick = p[bit_sel] ? c[7:4] : c[3:0];
        if (!reg_model.display_en || pick == 4'h0) begin
            pick = reg_model.backdrop;
        end
        return pick;
    endfunction

    function automatic vdp_pkg::byte_t expected_read(logic [14:0] adr);
        if (!adr[14]) begin
            return vram_model[adr[13:0]];
        end
        case (vdp_pkg::reg_index_e'(adr[2:0]))
            vdp_pkg::REG_MODE:         return {1'b0, reg_model.display_en, 6'b0};
            vdp_pkg::REG_NAME_BASE:    return {4'b0, reg_model.name_base};
            vdp_pkg::REG_COLOR_BASE:   return reg_model.color_base;
            vdp_pkg::REG_PATTERN_BASE: return {5'b0, reg_model.pattern_base};
            vdp_pkg::REG_BACKDROP:     return {4'b0, reg_model.backdrop};
            default:                   return 8'h00;
        endcase
    endfunction

    function automatic logic [14:0] reg_addr(vdp_pkg::reg_index_e idx);
        return {1'b1, 11'd0, idx};
    endfunction

    // ********************
    // compare tasks
    // ********************
    task automatic check_byte(input vdp_pkg::byte_t expected, input vdp_pkg::byte_t actual,
                              input string what);
        if (actual !== expected) begin
            $display("MISMATCH wb_dat_r %s: expected %h got %h", what, expected, actual);
            mismatches++;
        end
    endtask

    task automatic check_rgb(input vdp_pkg::color_t expected, input int x, input int y);
        logic [5:0] got;
        got = {red, grn, blu};
        if (got !== palette_rgb(expected)) begin
            $display("MISMATCH {red,grn,blu} at x=%0d y=%0d: expected %h (color %h) got %h",
                     x, y, palette_rgb(expected), expected, got);
            mismatches++;
        end
    endtask

    task automatic check_count(input int expected, input int actual, input string what);
        if (actual != expected) begin
            $display("MISMATCH %s: expected %h got %h", what, expected, actual);
            mismatches++;
        end
    endtask

    // ********************
    // bus driver
    // ********************
    task automatic bus_cycle(input logic [14:0] adr, input logic we, input vdp_pkg::byte_t wdata,
                             output vdp_pkg::byte_t rdata);
        int waited;
        waited = 0;
        rdata = '0;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        do begin
            @(negedge clk);
            waited++;
        end while (!wb_ack && waited < ACK_LIMIT);
        if (wb_ack) begin
            rdata = wb_dat_r;                   // valid while ack is high
        end else begin
            $display("no ack from the host port for address %h within %0d cycles",
                     adr, ACK_LIMIT);
            other_errors++;
        end
        @(negedge clk);                         // hold through the ack edge
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [14:0] adr, input vdp_pkg::byte_t data);
        vdp_pkg::byte_t discard;
        bus_cycle(adr, 1'b1, data, discard);
        if (!adr[14]) begin
            vram_model[adr[13:0]] = data;
        end else begin
            case (vdp_pkg::reg_index_e'(adr[2:0]))
                vdp_pkg::REG_MODE:         reg_model.display_en   = data[6];
                vdp_pkg::REG_NAME_BASE:    reg_model.name_base    = data[3:0];
                vdp_pkg::REG_COLOR_BASE:   reg_model.color_base   = data;
                vdp_pkg::REG_PATTERN_BASE: reg_model.pattern_base = data[2:0];
                vdp_pkg::REG_BACKDROP:     reg_model.backdrop     = data[3:0];
                default: ;
            endcase
        end
    endtask

    task automatic wb_read(input logic [14:0] adr, input string what);
        vdp_pkg::byte_t got;
        bus_cycle(adr, 1'b0, 8'h00, got);
        check_byte(expected_read(adr), got, what);
    endtask

    task automatic write_random(input int base, input int count);
        for (int i = 0; i < count; i++) begin
            wb_write(15'(base + i), 8'($random(seed)));
        end
    endtask

    // ********************
    // video capture
    // ********************
    task automatic wait_vsync_rise();
        logic prev;
        logic seen;
        prev = 1'b1;                            // needs a fresh rising edge
        seen = 1'b0;
        while (!seen) begin
            @(negedge clk);
            seen = vsync && !prev;
            prev = vsync;
        end
    endtask

    task automatic capture_frame();
        int k;
        k = 0;
        wait_vsync_rise();
        while (k < vdp_pkg::H_ACTIVE * vdp_pkg::V_ACTIVE) begin
            @(negedge clk);
            if (de) begin                       // raster order
                check_rgb(expected_color(k % vdp_pkg::H_ACTIVE, k / vdp_pkg::H_ACTIVE),
                          k % vdp_pkg::H_ACTIVE, k / vdp_pkg::H_ACTIVE);
                k++;
            end
        end
    endtask

    // ********************
    // tests
    // ********************
    task automatic test_readback();
        logic [14:0] vaddr [4];
        vaddr[0] = 15'h3fff;
        vaddr[1] = 15'h2a55;
        vaddr[2] = 15'h1234;
        vaddr[3] = 15'h0001;
        wb_write(reg_addr(vdp_pkg::REG_MODE), 8'h40);
        wb_write(reg_addr(vdp_pkg::REG_NAME_BASE), 8'h05);
        wb_write(reg_addr(vdp_pkg::REG_COLOR_BASE), 8'ha7);
        wb_write(reg_addr(vdp_pkg::REG_PATTERN_BASE), 8'h03);
        wb_write(reg_addr(vdp_pkg::REG_BACKDROP), 8'h0c);
        for (int i = 0; i < 4; i++) begin
            wb_write(vaddr[i], 8'($random(seed)));
        end
        wb_read(reg_addr(vdp_pkg::REG_MODE), "mode reg");
        wb_read(reg_addr(vdp_pkg::REG_NAME_BASE), "name base reg");
        wb_read(reg_addr(vdp_pkg::REG_COLOR_BASE), "color base reg");
        wb_read(reg_addr(vdp_pkg::REG_PATTERN_BASE), "pattern base reg");
        wb_read(reg_addr(vdp_pkg::REG_BACKDROP), "backdrop reg");
        for (int i = 0; i < 4; i++) begin
            wb_read(vaddr[i], $sformatf("vram %h", vaddr[i]));
        end
    endtask

    task automatic test_blank_backdrop();
        // white in every color entry the current tables can reach
        for (int i = 0; i < 32; i++) begin
            wb_write(15'(int'(reg_model.color_base) * 64 + i), 8'hff);
        end
        wb_write(reg_addr(vdp_pkg::REG_MODE), 8'h00);
        wb_write(reg_addr(vdp_pkg::REG_BACKDROP), 8'h04);
        capture_frame();
    endtask

    task automatic test_random_tables();
        vdp_pkg::byte_t c;
        write_random(NAME_A * 1024, NAME_BYTES);
        write_random(PATTERN_A * 2048, PAT_BYTES);
        write_random(NAME_B * 1024, NAME_BYTES);      // second set for the switch
        write_random(PATTERN_B * 2048, PAT_BYTES);
        for (int i = 0; i < 32; i++) begin
            c = 8'($random(seed));
            if (i < 16) begin
                c = {4'(i), 4'(15 - i)};        // every palette entry
            end
            wb_write(15'(COLOR_AT * 64 + i), c);
        end
        wb_write(reg_addr(vdp_pkg::REG_NAME_BASE), 8'(NAME_A));
        wb_write(reg_addr(vdp_pkg::REG_PATTERN_BASE), 8'(PATTERN_A));
        wb_write(reg_addr(vdp_pkg::REG_COLOR_BASE), 8'(COLOR_AT));
        wb_write(reg_addr(vdp_pkg::REG_MODE), 8'h40);
        capture_frame();
    endtask

    task automatic test_transparent();
        vdp_pkg::byte_t c;
        for (int i = 0; i < 32; i++) begin
            c = 8'($random(seed));
            case (i % 3)
                0:       c[7:4] = 4'h0;
                1:       c[3:0] = 4'h0;
                default: c = 8'h00;             // both halves show backdrop
            endcase
            wb_write(15'(COLOR_AT * 64 + i), c);
        end
        wb_write(reg_addr(vdp_pkg::REG_BACKDROP), 8'h09);
        capture_frame();
    endtask

    task automatic test_table_switch();
        wb_write(reg_addr(vdp_pkg::REG_NAME_BASE), 8'(NAME_B));
        wb_write(reg_addr(vdp_pkg::REG_PATTERN_BASE), 8'(PATTERN_B));
        capture_frame();
    endtask

    task automatic test_frame_structure();
        int  hs_pulses;
        int  lines;
        int  run;
        logic prev_hs;
        logic prev_vs;
        logic done;
        hs_pulses = 0;
        lines = 0;
        run = 0;
        prev_hs = 1'b0;
        prev_vs = 1'b1;
        done = 1'b0;
        wait_vsync_rise();
        while (!done) begin
            @(negedge clk);
            if (hsync && !prev_hs) begin
                hs_pulses++;
            end
            if (de) begin
                run++;
            end else if (run != 0) begin
                check_count(vdp_pkg::H_ACTIVE, run, "de cycles in line");
                lines++;
                run = 0;
            end
            done = vsync && !prev_vs;           // next frame's vsync
            prev_hs = hsync;
            prev_vs = vsync;
        end
        check_count(vdp_pkg::V_ACTIVE, lines, "de lines per frame");
        check_count(V_TOTAL, hs_pulses, "hsync pulses per frame");
    endtask

    // run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout, tests still running after %0d cycles", TIMEOUT_CYCLES);
            $display("errors: %0d mismatches, %0d other", mismatches, other_errors + 1);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        reg_model = '0;                         // registers clear after reset
        do begin
            @(negedge clk);
        end while (rst);
        test_readback();
        test_blank_backdrop();
        test_random_tables();
        test_transparent();
        test_table_switch();
        test_frame_structure();
        if (vdp_top_i.chk_i.failures != 0) begin
            $display("bound checker saw %0d failed assertions", vdp_top_i.chk_i.failures);
            other_errors += vdp_top_i.chk_i.failures;
        end
        $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
vdp_pkg.sv
vdp_host_port.sv
vdp_vram.sv
vdp_timing.sv
tile_fetch.sv
color_palette.sv
vdp_top.sv
tb_clock.sv
vdp_chk.sv
vdp_tb.sv

/* Makefile */
# Verilator build and run for the VDP testbench

VERILATOR ?= verilator
TOP       ?= vdp_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000

SOURCES := $(filter-out +%,$(shell cat compile.f))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): compile.f $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f compile.f

run: $(BIN)
	@out="$$($(BIN) $(SIM_ARGS))"; echo "$$out"; echo "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf $(OBJ_DIR)
